//--- files.f
+incdir+src
src/flit_buffer_pkg.sv
src/vc_request_decode.sv
src/vc_queue_ctrl.sv
src/flit_ram.sv
src/flit_buffer.sv
verification/flit_buffer_tb.sv

//--- src/flit_buffer.sv
`timescale 1ns/1ps
`default_nettype none

`include "flit_buffer_config.svh"

module flit_buffer (
    input  wire                          clk,
    input  wire                          reset,
    input  wire flit_buffer_pkg::flit_t  din,
    input  wire                          wr_en,
    input  wire                          rd_en,
    input  wire flit_buffer_pkg::vc_onehot_t vc_num_wr,
    input  wire flit_buffer_pkg::vc_onehot_t vc_num_rd,
    input  wire flit_buffer_pkg::vc_onehot_t ssa_rd,      // SSA pops, used when rd_en is low
    output wire flit_buffer_pkg::flit_t  dout,
    output wire flit_buffer_pkg::vc_onehot_t vc_not_empty
);

    import flit_buffer_pkg::*;

    // per-VC strobes
    wire vc_onehot_t wr_vc;
    wire vc_onehot_t rd_vc;

    // binary VC numbers for the RAM
    wire vc_index_t wr_index;
    wire vc_index_t rd_index;

    // one pointer slice per VC
    wire slot_ptr_t [`FB_VC_NUM-1:0] wr_ptr_all;
    wire slot_ptr_t [`FB_VC_NUM-1:0] rd_ptr_all;

    vc_request_decode decode_i (
        .wr_en     (wr_en),
        .rd_en     (rd_en),
        .vc_num_wr (vc_num_wr),
        .vc_num_rd (vc_num_rd),
        .ssa_rd    (ssa_rd),
        .wr_vc     (wr_vc),
        .rd_vc     (rd_vc),
        .wr_index  (wr_index),
        .rd_index  (rd_index)
    );

    // one queue controller per VC
    for (genvar i = 0; i < `FB_VC_NUM; i++) begin : vc_gen
        vc_queue_ctrl ctrl_i (
            .clk       (clk),
            .reset     (reset),
            .wr        (wr_vc[i]),
            .rd        (rd_vc[i]),
            .wr_ptr    (wr_ptr_all[i]),
            .rd_ptr    (rd_ptr_all[i]),
            .not_empty (vc_not_empty[i])
        );
    end

    // shared storage for all VCs
    flit_ram ram_i (
        .clk        (clk),
        .reset      (reset),
        .wr_en      (wr_en),
        .rd_en      (rd_en),
        .wr_index   (wr_index),
        .rd_index   (rd_index),
        .wr_ptr_all (wr_ptr_all),
        .rd_ptr_all (rd_ptr_all),
        .din        (din),
        .dout       (dout)
    );

endmodule

`default_nettype wire

//--- src/flit_buffer_config.svh
`ifndef FLIT_BUFFER_CONFIG_SVH
`define FLIT_BUFFER_CONFIG_SVH

// number of virtual channels sharing one input port
`define FB_VC_NUM 4

// flit slots per virtual channel
// must be a power of two and at least 2, so the pointers wrap on their own
`define FB_VC_DEPTH 4

// payload bits of one flit, head and tail bits come on top
`define FB_PAYLOAD_W 32

`endif

//--- src/flit_buffer_pkg.sv
`default_nettype none

`include "flit_buffer_config.svh"

package flit_buffer_pkg;

    // binary VC number, kept at least one bit wide for a single VC
    localparam int VC_IDX_W = (`FB_VC_NUM > 1) ? $clog2(`FB_VC_NUM) : 1;

    localparam int SLOT_PTR_W = $clog2(`FB_VC_DEPTH);   // slot within one VC
    localparam int FLIT_W = `FB_PAYLOAD_W + 2;           // head + tail + payload

    // one bit per VC
    typedef logic [`FB_VC_NUM-1:0] vc_onehot_t;

    typedef logic [VC_IDX_W-1:0] vc_index_t;

    typedef logic [SLOT_PTR_W-1:0] slot_ptr_t;

    // one bit wider so a full VC (value B) fits
    typedef logic [SLOT_PTR_W:0] depth_t;

    // VC index in the upper bits, slot pointer in the lower bits
    typedef logic [VC_IDX_W+SLOT_PTR_W-1:0] ram_addr_t;

    // head at the top, tail below it, then payload
    typedef logic [FLIT_W-1:0] flit_t;

endpackage

`default_nettype wire

//--- src/flit_ram.sv
`timescale 1ns/1ps
`default_nettype none

`include "flit_buffer_config.svh"

module flit_ram (
    input  wire                         clk,
    input  wire                         reset,
    input  wire                         wr_en,
    input  wire                         rd_en,
    input  wire flit_buffer_pkg::vc_index_t wr_index,
    input  wire flit_buffer_pkg::vc_index_t rd_index,
    input  wire flit_buffer_pkg::slot_ptr_t [`FB_VC_NUM-1:0] wr_ptr_all,
    input  wire flit_buffer_pkg::slot_ptr_t [`FB_VC_NUM-1:0] rd_ptr_all,
    input  wire flit_buffer_pkg::flit_t din,
    output flit_buffer_pkg::flit_t      dout
);

    import flit_buffer_pkg::*;

    // one block of slots per VC
    localparam int RAM_WORDS = 2 ** $bits(ram_addr_t);

    slot_ptr_t wr_slot;
    slot_ptr_t rd_slot;
    ram_addr_t wr_addr;
    ram_addr_t rd_addr;

    flit_t mem [RAM_WORDS];

    // pointer of the addressed VC
    assign wr_slot = wr_ptr_all[wr_index];
    assign rd_slot = rd_ptr_all[rd_index];   // value before the rd_en edge

    assign wr_addr = {wr_index, wr_slot};
    assign rd_addr = {rd_index, rd_slot};

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= din;
        end
    end

    // registered read
    // a full VC read and written together sees the old word, i.e. the oldest flit
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            dout <= '0;
        end else if (rd_en) begin
            dout <= mem[rd_addr];   // holds until the next read
        end
    end

    // the address comes from the decoder and the queue pointers together
    wr_addr_known_a: assert property (
        @(posedge clk) disable iff (reset)
        wr_en |-> !$isunknown(wr_addr)
    ) else $error("unknown write address %h with wr_en high", wr_addr);

endmodule

`default_nettype wire

//--- src/vc_queue_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "flit_buffer_config.svh"

module vc_queue_ctrl (
    input  wire                        clk,
    input  wire                        reset,
    input  wire                        wr,          // push into this VC
    input  wire                        rd,          // pop by a real read or an SSA
    output flit_buffer_pkg::slot_ptr_t wr_ptr,
    output flit_buffer_pkg::slot_ptr_t rd_ptr,
    output logic                       not_empty
);

    import flit_buffer_pkg::*;

    localparam depth_t DEPTH_FULL = depth_t'(`FB_VC_DEPTH);

    depth_t depth;   // flits currently held by this VC

    // pointers wrap by themselves since the depth is a power of two
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // a push and a pop together leave the occupancy unchanged
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            depth <= '0;
        end else if (wr && !rd) begin
            depth <= depth + 1'b1;
        end else if (rd && !wr) begin
            depth <= depth - 1'b1;
        end
    end

    assign not_empty = (depth != '0);

    // no back-pressure exists, so the requester has to respect the occupancy
    no_overflow_a: assert property (
        @(posedge clk) disable iff (reset)
        (wr && !rd) |-> (depth != DEPTH_FULL)
    ) else $error("write to a full VC without a read");

    no_underflow_a: assert property (
        @(posedge clk) disable iff (reset)
        (rd && !wr) |-> (depth != '0)
    ) else $error("pop from an empty VC without a write");

    // pointer distance equals the occupancy modulo the VC depth
    ptr_distance_a: assert property (
        @(posedge clk) disable iff (reset)
        (depth <= DEPTH_FULL) && (slot_ptr_t'(wr_ptr - rd_ptr) == slot_ptr_t'(depth))
    ) else $error("pointers %0d/%0d do not match occupancy %0d", wr_ptr, rd_ptr, depth);

endmodule

`default_nettype wire

//--- src/vc_request_decode.sv
`timescale 1ns/1ps
`default_nettype none

`include "flit_buffer_config.svh"

module vc_request_decode (
    input  wire                         wr_en,
    input  wire                         rd_en,
    input  wire flit_buffer_pkg::vc_onehot_t vc_num_wr,
    input  wire flit_buffer_pkg::vc_onehot_t vc_num_rd,
    input  wire flit_buffer_pkg::vc_onehot_t ssa_rd,
    output flit_buffer_pkg::vc_onehot_t wr_vc,
    output flit_buffer_pkg::vc_onehot_t rd_vc,
    output flit_buffer_pkg::vc_index_t  wr_index,
    output flit_buffer_pkg::vc_index_t  rd_index
);

    import flit_buffer_pkg::*;

    // ORs the positions of all set bits
    // exact only for a one-hot input, an unknown select bit gives an unknown index
    function automatic vc_index_t onehot_to_index(input vc_onehot_t sel);
        vc_index_t idx;
        idx = '0;
        for (int i = 0; i < `FB_VC_NUM; i++) begin
            idx = idx | ({VC_IDX_W{sel[i]}} & vc_index_t'(i));
        end
        return idx;
    endfunction

    // write strobe per VC
    assign wr_vc = wr_en ? vc_num_wr : '0;

    // a real read wins, otherwise the SSA pops go through
    assign rd_vc = rd_en ? vc_num_rd : ssa_rd;

    // binary VC numbers for the RAM address
    assign wr_index = onehot_to_index(wr_vc);
    assign rd_index = onehot_to_index(rd_vc);   // only used by the RAM when rd_en is high

    // select contract with the switch allocator upstream
    // a zero or multi-bit select would corrupt more than one queue
    always_comb begin
        if (wr_en === 1'b1) begin
            wr_sel_onehot_a: assert final ($onehot(vc_num_wr))
                else $error("vc_num_wr not one-hot while wr_en is high: %b", vc_num_wr);
        end
        if (rd_en === 1'b1) begin
            rd_sel_onehot_a: assert final ($onehot(vc_num_rd))
                else $error("vc_num_rd not one-hot while rd_en is high: %b", vc_num_rd);
        end
    end

endmodule

`default_nettype wire

//--- verification/flit_buffer_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "flit_buffer_config.svh"

module flit_buffer_tb;

    import flit_buffer_pkg::*;

    localparam int VC_NUM = `FB_VC_NUM;
    localparam int DEPTH = `FB_VC_DEPTH;
    localparam int RANDOM_CYCLES = 2000;
    localparam int TIMEOUT_CYCLES = 3000;   // directed ~200 plus random 2000

    logic clk = 1'b0;
    logic reset;
    flit_t din;
    logic wr_en;
    logic rd_en;
    vc_onehot_t vc_num_wr;
    vc_onehot_t vc_num_rd;
    vc_onehot_t ssa_rd;
    flit_t dout;
    vc_onehot_t vc_not_empty;

    integer seed = 32'h460f37a1;
    string test_name = "reset state";
    int cycle_count;

    // reference queues, one per VC
    flit_t model_q [VC_NUM][$];
    flit_t model_dout;          // dout after the next edge
    vc_onehot_t model_ne;
    logic model_rd;

    // model state lined up with the DUT outputs
    flit_t exp_dout;
    vc_onehot_t exp_ne;
    logic exp_rd;

    flit_buffer dut_i (
        .clk          (clk),
        .reset        (reset),
        .din          (din),
        .wr_en        (wr_en),
        .rd_en        (rd_en),
        .vc_num_wr    (vc_num_wr),
        .vc_num_rd    (vc_num_rd),
        .ssa_rd       (ssa_rd),
        .dout         (dout),
        .vc_not_empty (vc_not_empty)
    );

    always #50 clk = ~clk;

    always @(posedge clk or posedge reset) begin
        if (reset) begin
            exp_dout <= '0;
            exp_ne <= '0;
            exp_rd <= 1'b0;
        end else begin
            exp_dout <= model_dout;
            exp_ne <= model_ne;
            exp_rd <= model_rd;
        end
    end

    task automatic fail_value(input string check, input logic [63:0] expected,
                              input logic [63:0] actual);
        $display("[FAIL] %s: expected %h, actual %h", check, expected, actual);
        $display("TEST RESULT: FAIL");
        $fatal(1, "value mismatch");
    endtask

    task automatic fail_plain(input string what);
        $display("error: %s", what);
        $display("TEST RESULT: FAIL");
        $fatal(1, "run aborted");
    endtask

    reset_flags_a: assert property (@(posedge clk) reset |-> (vc_not_empty == '0))
        else fail_value("reset state: flags", '0, $sampled(vc_not_empty));

    after_reset_a: assert property (
        @(posedge clk) $fell(reset) |-> (vc_not_empty == '0 && dout == '0)
    ) else fail_value("first cycle after reset", '0, {$sampled(vc_not_empty), $sampled(dout)});

    read_data_a: assert property (
        @(posedge clk) disable iff (reset) exp_rd |-> (dout == exp_dout)
    ) else fail_value({test_name, ": read data"}, $sampled(exp_dout), $sampled(dout));

    // dout must not move without a real read, SSA pops included
    hold_data_a: assert property (
        @(posedge clk) disable iff (reset) !exp_rd |-> (dout == exp_dout)
    ) else fail_value({test_name, ": dout hold"}, $sampled(exp_dout), $sampled(dout));

    flags_a: assert property (
        @(posedge clk) disable iff (reset) vc_not_empty == exp_ne
    ) else fail_value({test_name, ": not-empty flags"}, $sampled(exp_ne),
                      $sampled(vc_not_empty));

    function automatic vc_onehot_t vc_bit(input int v);
        return vc_onehot_t'(1) << v;
    endfunction

    function automatic flit_t make_flit(input logic head, input logic tail, input int tag);
        logic [`FB_PAYLOAD_W-1:0] payload;
        payload = tag ^ 32'h5a3c_0000;
        return {head, tail, payload};
    endfunction

    // one strobe cycle, inputs land 1 ns after the edge
    task automatic drive_cycle(input logic w, input int wv, input flit_t f,
                               input logic r, input int rv, input vc_onehot_t ssa);
        @(posedge clk);
        #1;
        wr_en = w;
        vc_num_wr = w ? vc_bit(wv) : '0;
        din = f;
        rd_en = r;
        vc_num_rd = r ? vc_bit(rv) : '0;
        ssa_rd = ssa;
        model_rd = r;
        if (r) begin
            if (model_q[rv].size() == 0) fail_plain("stimulus reads an empty VC");
            model_dout = model_q[rv].pop_front();
        end else begin
            for (int v = 0; v < VC_NUM; v++) begin
                if (ssa[v]) begin
                    if (model_q[v].size() == 0) fail_plain("stimulus SSA-pops an empty VC");
                    void'(model_q[v].pop_front());
                end
            end
        end
        if (w) begin
            if (model_q[wv].size() >= DEPTH) fail_plain("stimulus overfills a VC");
            model_q[wv].push_back(f);
        end
        for (int v = 0; v < VC_NUM; v++) begin
            model_ne[v] = (model_q[v].size() != 0);
        end
    endtask

    task automatic idle_cycle();
        drive_cycle(1'b0, 0, '0, 1'b0, 0, '0);
    endtask

    // fill each VC, then drain it in order
    task automatic order_per_vc();
        test_name = "per-VC order";
        for (int v = 0; v < VC_NUM; v++) begin
            for (int i = 0; i < DEPTH; i++) begin
                drive_cycle(1'b1, v, make_flit(i == 0, i == DEPTH - 1, v * 256 + i),
                            1'b0, 0, '0);
            end
            for (int i = 0; i < DEPTH; i++) begin
                drive_cycle(1'b0, 0, '0, 1'b1, v, '0);
            end
            idle_cycle();
        end
    endtask

    task automatic ssa_pop_sequence();
        test_name = "SSA pop";
        for (int i = 0; i < 3; i++) begin
            drive_cycle(1'b1, 2, make_flit(1'b0, 1'b0, 16'h2200 + i), 1'b0, 0, '0);
        end
        drive_cycle(1'b0, 0, '0, 1'b1, 2, '0);          // oldest flit
        drive_cycle(1'b0, 0, '0, 1'b0, 0, vc_bit(2));   // drop the second
        drive_cycle(1'b0, 0, '0, 1'b1, 2, '0);          // third one comes out
        drive_cycle(1'b1, 2, make_flit(1'b1, 1'b0, 16'h2210), 1'b0, 0, '0);
        drive_cycle(1'b1, 2, make_flit(1'b0, 1'b1, 16'h2211), 1'b0, 0, vc_bit(2));
        drive_cycle(1'b0, 0, '0, 1'b1, 2, '0);
        // two VCs popped at once
        drive_cycle(1'b1, 0, make_flit(1'b1, 1'b1, 16'h0033), 1'b0, 0, '0);
        drive_cycle(1'b1, VC_NUM - 1, make_flit(1'b1, 1'b1, 16'h3333), 1'b0, 0, '0);
        drive_cycle(1'b0, 0, '0, 1'b0, 0, vc_bit(0) | vc_bit(VC_NUM - 1));
        idle_cycle();
    endtask

    task automatic full_vc_read_write();
        test_name = "same VC read and write";
        for (int i = 0; i < DEPTH; i++) begin
            drive_cycle(1'b1, 1, make_flit(i == 0, 1'b0, 16'h1100 + i), 1'b0, 0, '0);
        end
        // full VC, occupancy stays at the top
        for (int i = 0; i < DEPTH; i++) begin
            drive_cycle(1'b1, 1, make_flit(1'b0, i == DEPTH - 1, 16'h1180 + i), 1'b1, 1, '0);
        end
        for (int i = 0; i < DEPTH; i++) begin
            drive_cycle(1'b0, 0, '0, 1'b1, 1, '0);
        end
        idle_cycle();
    endtask

    task automatic random_traffic(input int cycles);
        logic w;
        logic r;
        int wv;
        int rv;
        vc_onehot_t ssa;
        flit_t f;
        test_name = "random traffic";
        for (int n = 0; n < cycles; n++) begin
            rv = $unsigned($random(seed)) % VC_NUM;
            r = (($random(seed) & 1) != 0) && (model_q[rv].size() != 0);
            ssa = '0;
            if (!r && (($random(seed) & 3) == 0)) begin
                ssa = vc_onehot_t'($random(seed)) & model_ne;
            end
            wv = $unsigned($random(seed)) % VC_NUM;
            w = (($random(seed) & 7) < 5) &&
                ((model_q[wv].size() < DEPTH) || (r && rv == wv) || (!r && ssa[wv]));
            f = flit_t'({$random(seed), $random(seed)});
            drive_cycle(w, wv, f, r, rv, ssa);
        end
    endtask

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        fail_plain("timeout, the test did not finish within the cycle limit");
    end

    initial begin
        reset = 1'b1;
        din = '0;
        wr_en = 1'b0;
        rd_en = 1'b0;
        vc_num_wr = '0;
        vc_num_rd = '0;
        ssa_rd = '0;
        model_dout = '0;
        model_ne = '0;
        model_rd = 1'b0;
        repeat (8) @(posedge clk);
        #1;
        reset = 1'b0;
        order_per_vc();
        ssa_pop_sequence();
        full_vc_read_write();
        random_traffic(RANDOM_CYCLES);
        idle_cycle();
        idle_cycle();   // last checks land here
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire
